// File: logic/pwl_params.svh
`ifndef PWL_PARAMS_SVH
`define PWL_PARAMS_SVH

// Sample, slope and start value width.
`define PWL_SAMPLE_W 16

`define PWL_BATCH 4 // Samples per output batch.

`define PWL_DEPTH 16 // Segment memory entries.

`define PWL_REPS_W 8 // Batches per segment field.

`endif

// File: logic/pwl_pkg.sv
`include "pwl_params.svh"

package pwl_pkg;

	typedef logic [`PWL_SAMPLE_W-1:0] sample_t;

	typedef logic [$clog2(`PWL_DEPTH)-1:0] seg_addr_t;
	typedef logic [$clog2(`PWL_DEPTH):0] seg_cnt_t; // Holds 0 to full depth.

	typedef struct packed {
		sample_t x; // Start value.
		sample_t slope; // Step per sample.
		logic [`PWL_REPS_W-1:0] reps; // Whole batches.
	} pwl_seg_t;

	typedef struct packed {
		pwl_seg_t seg;
		logic last; // Ends the program.
	} pwl_beat_t;

	typedef logic [`PWL_BATCH-1:0][`PWL_SAMPLE_W-1:0] pwl_batch_t;

	typedef enum logic {
		LD_IDLE,
		LD_FILL
	} loader_state_e;

	typedef enum logic [1:0] {
		PL_IDLE,
		PL_FETCH,
		PL_SEND,
		PL_HALT
	} player_state_e;

endpackage

// File: logic/pwl_cmd_loader.sv
`timescale 1ns/1ps
`include "pwl_params.svh"

module pwl_cmd_loader import pwl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic s_valid,
	output logic s_ready,
	input pwl_beat_t s_beat,
	input logic busy,
	output logic wr_en,
	output seg_addr_t wr_addr,
	output pwl_seg_t wr_seg,
	output seg_cnt_t seg_count,
	output logic prog_valid
);

	loader_state_e state;
	seg_cnt_t fill_cnt; // Segments stored so far.
	seg_cnt_t cnt_base;
	seg_cnt_t next_cnt;
	logic accept;
	logic room;

	assign s_ready = !busy;
	assign accept = s_valid && s_ready;

	// A beat seen in LD_IDLE opens a new program at address 0.
	assign cnt_base = (state == LD_IDLE) ? '0 : fill_cnt;
	assign room = cnt_base < seg_cnt_t'(`PWL_DEPTH);
	assign next_cnt = room ? cnt_base + 1'b1 : cnt_base; // Saturates when full.

	assign wr_en = accept && room; // Beats past the end are dropped.
	assign wr_addr = cnt_base[$bits(seg_addr_t)-1:0];
	assign wr_seg = s_beat.seg;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= LD_IDLE;
			fill_cnt <= '0;
			seg_count <= '0;
			prog_valid <= 1'b0;
		end else begin
			case (state)
				LD_IDLE: begin
					if (accept) begin
						fill_cnt <= next_cnt;
						if (s_beat.last) begin
							seg_count <= next_cnt; // One-beat program.
							prog_valid <= 1'b1;
						end else begin
							prog_valid <= 1'b0; // Old program is gone.
							state <= LD_FILL;
						end
					end
				end

				LD_FILL: begin
					if (accept) begin
						fill_cnt <= next_cnt;
						if (s_beat.last) begin
							seg_count <= next_cnt;
							prog_valid <= 1'b1;
							state <= LD_IDLE;
						end
					end
				end

				default: begin
					state <= LD_IDLE;
				end
			endcase
		end
	end

endmodule

// File: logic/pwl_segment_ram.sv
`timescale 1ns/1ps
`include "pwl_params.svh"

module pwl_segment_ram import pwl_pkg::*; (
	input logic clk,
	input logic wr_en,
	input seg_addr_t wr_addr,
	input pwl_seg_t wr_seg,
	input seg_addr_t rd_addr,
	output pwl_seg_t rd_seg
);

	pwl_seg_t mem [`PWL_DEPTH];

	// Write port.
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_seg;
		end
	end

	// Read port, one cycle of latency like a block RAM.
	always_ff @(posedge clk) begin
		rd_seg <= mem[rd_addr];
	end

endmodule

// File: logic/pwl_batch_player.sv
`timescale 1ns/1ps
`include "pwl_params.svh"

module pwl_batch_player import pwl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic run,
	input logic halt,
	input seg_cnt_t seg_count,
	input logic prog_valid,
	output seg_addr_t rd_addr,
	input pwl_seg_t rd_seg,
	output logic m_valid,
	input logic m_ready,
	output pwl_batch_t m_batch,
	output logic busy,
	output logic rdy_to_run
);

	player_state_e state;
	seg_addr_t seg_idx; // Segment being played.
	logic fetch_ph; // High once rd_seg holds seg_idx.
	sample_t base; // First sample of the batch on m_batch.
	sample_t slope;
	logic [`PWL_REPS_W-1:0] reps_left;

	logic handshake;
	logic fetch_load;
	logic last_batch;
	seg_cnt_t idx_inc;
	seg_addr_t next_idx;
	sample_t base_step;
	sample_t src_base;
	sample_t src_slope;
	pwl_batch_t next_batch;

	assign rd_addr = seg_idx;
	assign busy = (state != PL_IDLE);
	assign rdy_to_run = prog_valid && (state == PL_IDLE);

	assign handshake = m_valid && m_ready;
	assign fetch_load = (state == PL_FETCH) && fetch_ph;
	assign last_batch = (reps_left <= 1); // A zero count plays once.

	// Wrap from the last stored segment back to the first.
	assign idx_inc = {1'b0, seg_idx} + 1'b1;
	assign next_idx = (idx_inc >= seg_count) ? '0 : idx_inc[$bits(seg_addr_t)-1:0];

	assign base_step = base + slope * sample_t'(`PWL_BATCH);

	// Lane values for the next batch on m_batch.
	always_comb begin
		src_base = fetch_load ? rd_seg.x : base_step;
		src_slope = fetch_load ? rd_seg.slope : slope;
		for (int i = 0; i < `PWL_BATCH; i++) begin
			next_batch[i] = src_base + src_slope * sample_t'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= PL_IDLE;
			seg_idx <= '0;
			fetch_ph <= 1'b0;
			m_valid <= 1'b0;
		end else begin
			case (state)
				PL_IDLE: begin
					if (run && rdy_to_run) begin
						seg_idx <= '0;
						fetch_ph <= 1'b0;
						state <= PL_FETCH;
					end
				end

				PL_FETCH: begin
					if (halt) begin
						state <= PL_HALT;
					end else if (!fetch_ph) begin
						fetch_ph <= 1'b1; // Memory read in flight.
					end else begin
						m_valid <= 1'b1;
						state <= PL_SEND;
					end
				end

				PL_SEND: begin
					if (handshake) begin
						if (halt) begin
							m_valid <= 1'b0;
							state <= PL_HALT;
						end else if (last_batch) begin
							m_valid <= 1'b0;
							seg_idx <= next_idx;
							fetch_ph <= 1'b0;
							state <= PL_FETCH;
						end
					end
				end

				PL_HALT: begin
					m_valid <= 1'b0;
					state <= PL_IDLE;
				end

				default: begin
					state <= PL_IDLE;
				end
			endcase
		end
	end

	// Segment registers and the batch itself carry no reset.
	always_ff @(posedge clk) begin
		if (fetch_load) begin
			base <= rd_seg.x;
			slope <= rd_seg.slope;
			reps_left <= rd_seg.reps;
			m_batch <= next_batch;
		end else if (state == PL_SEND && handshake && !last_batch) begin
			base <= base_step; // Next batch of the same segment.
			reps_left <= reps_left - 1'b1;
			m_batch <= next_batch;
		end
	end

endmodule

// File: logic/pwl_top.sv
`timescale 1ns/1ps
`include "pwl_params.svh"

module pwl_top import pwl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic s_valid,
	output logic s_ready,
	input pwl_beat_t s_beat,
	output logic m_valid,
	input logic m_ready,
	output pwl_batch_t m_batch,
	input logic run,
	input logic halt,
	output logic rdy_to_run
);

	logic wr_en;
	seg_addr_t wr_addr;
	pwl_seg_t wr_seg;
	seg_cnt_t seg_count;
	logic prog_valid;
	seg_addr_t rd_addr;
	pwl_seg_t rd_seg;
	logic busy;

	pwl_cmd_loader i_loader (
		.clk(clk),
		.rst(rst),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.s_beat(s_beat),
		.busy(busy),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_seg(wr_seg),
		.seg_count(seg_count),
		.prog_valid(prog_valid)
	);

	pwl_segment_ram i_ram (
		.clk(clk),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_seg(wr_seg),
		.rd_addr(rd_addr),
		.rd_seg(rd_seg)
	);

	pwl_batch_player i_player (
		.clk(clk),
		.rst(rst),
		.run(run),
		.halt(halt),
		.seg_count(seg_count),
		.prog_valid(prog_valid),
		.rd_addr(rd_addr),
		.rd_seg(rd_seg),
		.m_valid(m_valid),
		.m_ready(m_ready),
		.m_batch(m_batch),
		.busy(busy),
		.rdy_to_run(rdy_to_run)
	);

endmodule

// File: dv/pwl_checker.sv
`timescale 1ns/1ps

module pwl_checker import pwl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic m_valid,
	input logic m_ready,
	input pwl_batch_t m_batch,
	input logic wr_en,
	input logic busy
);

	// A stalled batch stays put until it is taken.
	property batch_held;
		@(posedge clk) disable iff (rst)
		m_valid && !m_ready |=> m_valid && $stable(m_batch);
	endproperty

	property quiet_after_reset;
		@(posedge clk) rst |=> !m_valid && !wr_en;
	endproperty

	// The program being played is never rewritten.
	property no_load_while_busy;
		@(posedge clk) busy |-> !wr_en;
	endproperty

	a_batch_held: assert property (batch_held)
		else $error("m_batch or m_valid changed while the output was stalled");
	a_quiet_after_reset: assert property (quiet_after_reset)
		else $error("m_valid or wr_en high in the cycle after reset");
	a_no_load_while_busy: assert property (no_load_while_busy)
		else $error("segment memory written while the player is busy");

endmodule

bind pwl_top pwl_checker i_checker (
	.clk(clk),
	.rst(rst),
	.m_valid(m_valid),
	.m_ready(m_ready),
	.m_batch(m_batch),
	.wr_en(wr_en),
	.busy(busy)
);

// File: dv/pwl_tb.sv
`timescale 1ns/1ps
`include "pwl_params.svh"

module pwl_tb import pwl_pkg::*; ();

	typedef struct packed {
		logic [7:0] op;
		logic [8*16-1:0] name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
	} cmd_t;

	logic clk = 1'b0;
	logic rst;
	logic s_valid;
	logic s_ready;
	pwl_beat_t s_beat;
	logic m_valid;
	logic m_ready;
	pwl_batch_t m_batch;
	logic run;
	logic halt;
	logic rdy_to_run;

	cmd_t cmds[$];
	logic [31:0] exp_first[$]; // From the E lines, in order.
	logic [31:0] exp_last[$];
	logic [8*16-1:0] test_name;
	logic [31:0] rng = 32'he352_7067;
	int limit_cycles = 0;
	int total_batches = 0;

	// Reference copy of the stored program and the play position.
	pwl_seg_t model_prog [`PWL_DEPTH];
	int model_fill;
	int model_len;
	int model_idx;
	int model_k;
	logic model_open;

	pwl_top i_dut (
		.clk(clk),
		.rst(rst),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.s_beat(s_beat),
		.m_valid(m_valid),
		.m_ready(m_ready),
		.m_batch(m_batch),
		.run(run),
		.halt(halt),
		.rdy_to_run(rdy_to_run)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		fail_run($sformatf("Timeout: the run did not finish within %0d cycles", limit_cycles));
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Sample i of batch k is x + slope * (k * BATCH + i), 16-bit wrap.
	function automatic sample_t model_lane(input pwl_seg_t seg, input int k, input int lane);
		return seg.x + seg.slope * sample_t'(k * `PWL_BATCH + lane);
	endfunction

	// Fields that follow each trace command.
	function automatic int field_count(input logic [7:0] op);
		case (op)
			"T", "S": return 1;
			"L": return 4;
			"P", "E": return 2;
			default: return 0;
		endcase
	endfunction

	task automatic fail_run(input string why);
		$display("%0s", why);
		$display("Test failures found");
		$fatal(1, "run stopped");
	endtask

	task automatic compare(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			fail_run($sformatf("Error: test %0s, %0s: expected %h, actual %h",
				test_name, what, expected, actual));
		end
	endtask

	task automatic read_trace();
		int fd;
		int code;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [8*16-1:0] name;
		logic [8*200-1:0] line_buf;
		fd = $fopen("dv/pwl_trace.txt", "r");
		if (fd == 0) begin
			fail_run("Could not open the trace file dv/pwl_trace.txt");
		end
		while ($fscanf(fd, " %c", op) == 1) begin
			a = '0;
			b = '0;
			c = '0;
			d = '0;
			name = '0;
			case (op)
				"#": code = $fgets(line_buf, fd); // Rest of the line.
				"T": code = $fscanf(fd, "%s", name);
				"L": code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
				"P": code = $fscanf(fd, "%d %h", a, b);
				"S": code = $fscanf(fd, "%d", a);
				"E": code = $fscanf(fd, "%h %h", a, b);
				"R", "H", "X": code = 0;
				default: fail_run($sformatf("Unknown command '%c' in the trace file", op));
			endcase
			if (op != "#" && code != field_count(op)) begin
				fail_run($sformatf("Missing fields after command '%c' in the trace file", op));
			end
			if (op == "E") begin
				exp_first.push_back(a);
				exp_last.push_back(b);
			end else if (op != "#") begin
				cmds.push_back({op, name, a, b, c, d});
				if (op == "P") begin
					total_batches += int'(a);
				end
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		s_valid = 1'b0;
		run = 1'b0;
		halt = 1'b0;
		m_ready = 1'b0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		model_len = 0;
		model_open = 1'b0;
		compare("m_valid after reset", 0, {31'b0, m_valid});
		compare("rdy_to_run after reset", 0, {31'b0, rdy_to_run});
		compare("s_ready after reset", 1, {31'b0, s_ready});
	endtask

	task automatic load_beat(input sample_t x, input sample_t slope,
			input logic [`PWL_REPS_W-1:0] reps, input logic last);
		s_beat.seg.x = x;
		s_beat.seg.slope = slope;
		s_beat.seg.reps = reps;
		s_beat.last = last;
		s_valid = 1'b1;
		while (!s_ready) @(negedge clk);
		@(negedge clk); // Taken at the edge just passed.
		s_valid = 1'b0;
		if (!model_open) begin
			model_fill = 0;
		end
		if (model_fill < `PWL_DEPTH) begin
			model_prog[model_fill] = s_beat.seg;
			model_fill++;
		end
		model_open = !last;
		if (last) begin
			model_len = model_fill;
		end
	endtask

	task automatic start_run();
		compare("rdy_to_run before run", 1, {31'b0, rdy_to_run});
		run = 1'b1;
		@(negedge clk);
		run = 1'b0;
		compare("s_ready while playing", 0, {31'b0, s_ready});
		s_valid = 1'b1; // Beat offered mid-play must be refused.
		@(negedge clk);
		s_valid = 1'b0;
		model_idx = 0;
		model_k = 0;
	endtask

	task automatic halt_player();
		halt = 1'b1;
		m_ready = 1'b1; // A pending batch must go for the halt to land.
		@(negedge clk);
		while (!s_ready) @(negedge clk);
		halt = 1'b0;
		m_ready = 1'b0;
		compare("m_valid after halt", 0, {31'b0, m_valid});
	endtask

	task automatic check_batch(input pwl_batch_t seen);
		pwl_seg_t seg;
		logic [31:0] trace_first;
		logic [31:0] trace_last;
		if (exp_first.size() == 0) begin
			fail_run("The trace has fewer E lines than played batches");
		end
		trace_first = exp_first.pop_front();
		trace_last = exp_last.pop_front();
		seg = model_prog[model_idx];
		compare("trace first vs model", {16'b0, model_lane(seg, model_k, 0)}, trace_first);
		compare("trace last vs model", {16'b0, model_lane(seg, model_k, `PWL_BATCH - 1)},
			trace_last);
		compare("trace first vs DUT", trace_first, {16'b0, seen[0]});
		compare("trace last vs DUT", trace_last, {16'b0, seen[`PWL_BATCH-1]});
		for (int i = 0; i < `PWL_BATCH; i++) begin
			compare($sformatf("lane %0d", i), {16'b0, model_lane(seg, model_k, i)},
				{16'b0, seen[i]});
		end
		model_k++;
		if (model_k >= ((seg.reps == 0) ? 1 : int'(seg.reps))) begin
			model_k = 0;
			model_idx = (model_idx + 1 >= model_len) ? 0 : model_idx + 1;
		end
	endtask

	// Ready is random per cycle; a set mask bit makes it rarer.
	task automatic play_batches(input int count, input logic [31:0] mask);
		int got;
		got = 0;
		while (got < count) begin
			rng = lcg_next(rng);
			m_ready = (rng[31:16] & mask[15:0]) == 16'd0;
			if (m_valid && m_ready) begin
				check_batch(m_batch);
				got++;
			end
			@(negedge clk);
		end
		m_ready = 1'b0;
	endtask

	initial begin
		rst = 1'b1;
		s_valid = 1'b0;
		s_beat = '0;
		m_ready = 1'b0;
		run = 1'b0;
		halt = 1'b0;
		test_name = "setup";
		model_fill = 0;
		model_len = 0;
		model_idx = 0;
		model_k = 0;
		model_open = 1'b0;
		read_trace();
		limit_cycles = total_batches * 20 + 1000;
		apply_reset();
		foreach (cmds[j]) begin
			case (cmds[j].op)
				"T": test_name = cmds[j].name;
				"L": load_beat(cmds[j].a[15:0], cmds[j].b[15:0],
					cmds[j].c[`PWL_REPS_W-1:0], cmds[j].d[0]);
				"R": start_run();
				"H": halt_player();
				"X": apply_reset();
				"S": compare("rdy_to_run", cmds[j].a, {31'b0, rdy_to_run});
				"P": play_batches(int'(cmds[j].a), cmds[j].b);
				default: fail_run("Unexpected command in the trace list");
			endcase
		end
		compare("unused E lines", 0, exp_first.size());
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: list.f
+incdir+logic
logic/pwl_pkg.sv
logic/pwl_cmd_loader.sv
logic/pwl_segment_ram.sv
logic/pwl_batch_player.sv
logic/pwl_top.sv
dv/pwl_checker.sv
dv/pwl_tb.sv

// File: Makefile
# Verilator build and run of the PWL generator testbench.

TOP = pwl_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: dv/pwl_trace.txt
# Fields in hex except P count and S level. # starts a comment. Commands may share a line.
# T name | L x slope reps last | R | H | X | S rdy_to_run | P count ready_mask | E first last
T single
L 0004 fffd 03 1
S 1
R
P 4 0
E 0004 fffb
E fff8 ffef
E ffec ffe3
E 0004 fffb
H
T loop
L 0100 0001 02 0
L 8000 0010 01 1
R
P 4 0
E 0100 0103  E 0104 0107  E 8000 8030  E 0100 0103
T pressure
P 5 3
E 0104 0107  E 8000 8030  E 0100 0103  E 0104 0107  E 8000 8030
H
T reload
L 0010 0002 01 0
S 0
L 2000 ffff 01 1
S 1
R
P 3 1
E 0010 0016  E 2000 1ffd  E 0010 0016
H
T overlong
# Seventeen beats, the last one does not fit and is dropped.
L 0000 0001 01 0  L 0100 0001 01 0  L 0200 0001 01 0  L 0300 0001 01 0
L 0400 0001 01 0  L 0500 0001 01 0  L 0600 0001 01 0  L 0700 0001 01 0
L 0800 0001 01 0  L 0900 0001 01 0  L 0a00 0001 01 0  L 0b00 0001 01 0
L 0c00 0001 01 0  L 0d00 0001 01 0  L 0e00 0001 01 0  L 0f00 0001 01 0
L 7777 0001 01 1
S 1
R
P 17 1
E 0000 0003  E 0100 0103  E 0200 0203  E 0300 0303
E 0400 0403  E 0500 0503  E 0600 0603  E 0700 0703
E 0800 0803  E 0900 0903  E 0a00 0a03  E 0b00 0b03
E 0c00 0c03  E 0d00 0d03  E 0e00 0e03  E 0f00 0f03
E 0000 0003
T reset
X
S 0
L 0500 0100 02 1
S 1
R
P 2 0
E 0500 0800  E 0900 0c00
